//--- verilog/dcache_config.svh
// Geometry of the level-one data cache
// The index always sits directly above the byte offset of a line
// Way count must be a power of two and match DC_WAY_BITS
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// ==========================================================================
// Cache organisation
// ==========================================================================
`define DC_WAYS         4
`define DC_WAY_BITS     2
`define DC_LINES        16
`define DC_INDEX_BITS   4
`define DC_LINE_BITS    64
`define DC_OFFSET_BITS  3

// Address and identifier widths
`define DC_VADR_BITS    32
`define DC_PADR_BITS    32
`define DC_ASID_BITS    8
`define DC_CID_BITS     4
`define DC_CFG_BITS     16

`endif

//--- verilog/dcache_addr_pkg.sv
// Address-side types of the data cache
// Virtual and physical tags both start right above the set index
// Virtual and physical addresses are assumed to share the same index bits
`include "dcache_config.svh"

package dcache_addr_pkg;

	// Full virtual address as seen by the requester
	typedef logic [`DC_VADR_BITS-1:0] vadr_t;

	// Physical address, used by snoops and by the dump path
	typedef logic [`DC_PADR_BITS-1:0] padr_t;

	// Set index, taken from the bits just above the byte offset
	typedef logic [`DC_INDEX_BITS-1:0] index_t;

	// Virtual tag is everything above index and offset
	typedef logic [`DC_VADR_BITS-`DC_INDEX_BITS-`DC_OFFSET_BITS-1:0] vtag_t;

	// Physical tag, kept per line for snoop matching and dumps
	typedef logic [`DC_PADR_BITS-`DC_INDEX_BITS-`DC_OFFSET_BITS-1:0] ptag_t;

	// Address-space identifier stored alongside the virtual tag
	typedef logic [`DC_ASID_BITS-1:0] asid_t;

	// Bus channel identifier, used to ignore our own snoops
	typedef logic [`DC_CID_BITS-1:0] chan_id_t;

endpackage

//--- verilog/dcache_line_pkg.sv
// Line-side types of the data cache
// A line is a single data word, so a byte select covers the whole line
// Way masks carry one bit per way, bit n belongs to way n
`include "dcache_config.svh"

package dcache_line_pkg;

	// Data held by one cache line
	typedef logic [`DC_LINE_BITS-1:0] line_t;

	// One enable per byte of the line
	typedef logic [`DC_LINE_BITS/8-1:0] bsel_t;

	// Way number
	typedef logic [`DC_WAY_BITS-1:0] way_t;

	// Per-way state bits such as hit, valid or modified
	typedef logic [`DC_WAYS-1:0] way_mask_t;

endpackage

//--- verilog/dcache_ctrl_regs.sv
// Configuration register block beside the cache logic
// Address 0 holds enable in bit 0 and the channel id in bits 7:4
// Address 1 is write-only commands: bit 0 invalidate all, bit 1 one line
// Command strobes come out one clock after the write, no read port exists
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl_regs (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         cfg_we_i,
	input  logic                         cfg_addr_i,
	input  logic [`DC_CFG_BITS-1:0]      cfg_wdata_i,
	output logic                         enable_o,
	output dcache_addr_pkg::chan_id_t    chan_id_o,
	output logic                         inv_all_o,
	output logic                         inv_line_o,
	output dcache_addr_pkg::index_t      inv_index_o
);

	// Field positions inside the written word
	localparam int CID_LSB   = 4;
	localparam int INDEX_LSB = 8;

	logic mode_we;
	logic cmd_we;

	// ======================================================================
	// Address decode
	// ======================================================================

	// Only two registers exist, so the single address bit picks one
	assign mode_we = cfg_we_i && !cfg_addr_i;
	assign cmd_we  = cfg_we_i && cfg_addr_i;

	// Mode register, enable and own channel id both clear on reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			enable_o  <= 1'b0;
			chan_id_o <= '0;
		end else if (mode_we) begin
			enable_o  <= cfg_wdata_i[0];
			chan_id_o <= cfg_wdata_i[CID_LSB +: `DC_CID_BITS];
		end
	end

	// ======================================================================
	// Invalidate commands
	// ======================================================================

	// Each command write turns into a strobe lasting exactly one clock
	// The store acts on it at the following edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			inv_all_o  <= 1'b0;
			inv_line_o <= 1'b0;
		end else begin
			inv_all_o  <= cmd_we && cfg_wdata_i[0];
			inv_line_o <= cmd_we && cfg_wdata_i[1];
		end
	end

	// Line index for the invalidate-line command
	// Only looked at while inv_line_o is high
	always_ff @(posedge clk) begin
		if (cmd_we)
			inv_index_o <= cfg_wdata_i[INDEX_LSB +: `DC_INDEX_BITS];
	end

endmodule

//--- verilog/dcache_way_store.sv
// Storage for one way of the cache, held in flip-flops
// All reads are combinational at the request and snoop indexes
// A fill overrides any invalidation aimed at the same line in that cycle
// Only valid and modified bits are reset, tags and data power up unknown
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_way_store (
	input  logic                       clk,
	input  logic                       rst,
	input  dcache_addr_pkg::index_t    index_i,
	input  dcache_addr_pkg::vtag_t     vtag_i,
	input  dcache_addr_pkg::asid_t     asid_i,
	input  dcache_addr_pkg::index_t    snoop_index_i,
	input  dcache_addr_pkg::ptag_t     snoop_ptag_i,
	input  logic                       snoop_en_i,
	input  logic                       fill_i,
	input  dcache_addr_pkg::ptag_t     fill_ptag_i,
	input  dcache_line_pkg::line_t     fill_data_i,
	input  logic                       wr_i,
	input  dcache_line_pkg::line_t     wdata_i,
	input  dcache_line_pkg::bsel_t     bsel_i,
	input  logic                       inv_all_i,
	input  logic                       inv_line_i,
	input  dcache_addr_pkg::index_t    inv_index_i,
	output logic                       hit_o,
	output logic                       valid_o,
	output logic                       dirty_o,
	output dcache_line_pkg::line_t     data_o,
	output dcache_addr_pkg::ptag_t     ptag_o
);

	localparam int NBYTES = `DC_LINE_BITS / 8;

	logic [`DC_LINES-1:0]    valid_q;
	logic [`DC_LINES-1:0]    dirty_q;
	dcache_addr_pkg::asid_t  asid_q [`DC_LINES];
	dcache_addr_pkg::vtag_t  vtag_q [`DC_LINES];
	dcache_addr_pkg::ptag_t  ptag_q [`DC_LINES];
	dcache_line_pkg::line_t  data_q [`DC_LINES];
	logic                    snoop_hit;

	// Lookup side, the line hits only when valid and both tag and asid agree
	assign hit_o   = valid_q[index_i] && (vtag_q[index_i] == vtag_i) &&
			(asid_q[index_i] == asid_i);
	assign valid_o = valid_q[index_i];
	assign dirty_o = dirty_q[index_i];
	assign data_o  = data_q[index_i];
	assign ptag_o  = ptag_q[index_i];

	// Snoop side uses its own index into the physical tag array
	// The stored ptag is compared even for invalid lines, clearing those is harmless
	assign snoop_hit = snoop_en_i && (ptag_q[snoop_index_i] == snoop_ptag_i);

	// ======================================================================
	// State bits
	// ======================================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (inv_all_i)
				valid_q <= '0;
			if (inv_line_i)
				valid_q[inv_index_i] <= 1'b0;
			if (snoop_hit)
				valid_q[snoop_index_i] <= 1'b0;
			// Write hits mark the line modified
			if (wr_i)
				dirty_q[index_i] <= 1'b1;
			// A freshly loaded line is valid and clean, placed last so it wins
			if (fill_i) begin
				valid_q[index_i] <= 1'b1;
				dirty_q[index_i] <= 1'b0;
			end
		end
	end

	// ======================================================================
	// Tags and data
	// ======================================================================
	always_ff @(posedge clk) begin
		if (fill_i) begin
			vtag_q[index_i] <= vtag_i;
			asid_q[index_i] <= asid_i;
			ptag_q[index_i] <= fill_ptag_i;
			data_q[index_i] <= fill_data_i;
		end else if (wr_i) begin
			// Byte-masked update of the hit line
			for (int b = 0; b < NBYTES; b++) begin
				if (bsel_i[b])
					data_q[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
			end
		end
	end

endmodule

//--- verilog/dcache_victim.sv
// Victim way selection and dirty-line dump for line fills
// The lowest-numbered invalid way wins, otherwise a free-running LFSR picks
// The dump is a single-cycle strobe with no acknowledge or back-pressure
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_victim (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic                                        fill_i,
	input  dcache_line_pkg::way_mask_t                  valid_i,
	input  dcache_line_pkg::way_mask_t                  dirty_i,
	input  dcache_addr_pkg::ptag_t [`DC_WAYS-1:0]       ptag_i,
	input  dcache_line_pkg::line_t [`DC_WAYS-1:0]       data_i,
	input  dcache_addr_pkg::index_t                     index_i,
	output dcache_line_pkg::way_t                       victim_way_o,
	output logic                                        dump_o,
	output dcache_addr_pkg::padr_t                      dump_padr_o,
	output dcache_line_pkg::line_t                      dump_data_o
);

	logic [16:0] lfsr_q;
	logic        dump_now;

	// Maximal-length 17-bit LFSR, polynomial x^17 + x^14 + 1
	// Seeded non-zero so it never locks up
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			lfsr_q <= 17'h1;
		else
			lfsr_q <= {lfsr_q[15:0], lfsr_q[16] ^ lfsr_q[13]};
	end

	// Scan downward so the lowest invalid way is the one left standing
	always_comb begin
		victim_way_o = lfsr_q[`DC_WAY_BITS-1:0];
		for (int w = `DC_WAYS - 1; w >= 0; w--) begin
			if (!valid_i[w])
				victim_way_o = dcache_line_pkg::way_t'(w);
		end
	end

	// Modified data must go back to memory before the fill overwrites it
	assign dump_now = fill_i && valid_i[victim_way_o] && dirty_i[victim_way_o];

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			dump_o <= 1'b0;
		else
			dump_o <= dump_now;
	end

	// The address is rebuilt from the victim's physical tag and the set index
	always_ff @(posedge clk) begin
		if (dump_now) begin
			dump_padr_o <= {ptag_i[victim_way_o], index_i, {`DC_OFFSET_BITS{1'b0}}};
			dump_data_o <= data_i[victim_way_o];
		end
	end

endmodule

//--- verilog/dcache_core.sv
// Cache datapath: way stores, hit selection, write and fill steering
// Lookups answer one clock after req_i, dumps one clock after fill_i
// A write that misses does not allocate, and nothing hits while disabled
// req_i and fill_i are assumed never to be high in the same cycle
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_core (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        enable_i,
	input  dcache_addr_pkg::chan_id_t   chan_id_i,
	input  logic                        req_i,
	input  logic                        we_i,
	input  dcache_addr_pkg::vadr_t      vadr_i,
	input  dcache_addr_pkg::asid_t      asid_i,
	input  dcache_line_pkg::line_t      wdata_i,
	input  dcache_line_pkg::bsel_t      bsel_i,
	input  logic                        fill_i,
	input  dcache_addr_pkg::ptag_t      fill_ptag_i,
	input  dcache_line_pkg::line_t      fill_data_i,
	input  logic                        snoop_v_i,
	input  dcache_addr_pkg::padr_t      snoop_padr_i,
	input  dcache_addr_pkg::chan_id_t   snoop_cid_i,
	input  logic                        inv_all_i,
	input  logic                        inv_line_i,
	input  dcache_addr_pkg::index_t     inv_index_i,
	output logic                        resp_valid_o,
	output logic                        hit_o,
	output dcache_line_pkg::line_t      rdata_o,
	output logic                        dump_o,
	output dcache_addr_pkg::padr_t      dump_padr_o,
	output dcache_line_pkg::line_t      dump_data_o
);

	localparam int TAG_LSB = `DC_OFFSET_BITS + `DC_INDEX_BITS;

	dcache_addr_pkg::index_t                  index;
	dcache_addr_pkg::vtag_t                   vtag;
	dcache_addr_pkg::index_t                  snoop_index;
	dcache_addr_pkg::ptag_t                   snoop_ptag;
	logic                                     snoop_en;
	dcache_line_pkg::way_mask_t               way_hit;
	dcache_line_pkg::way_mask_t               way_valid;
	dcache_line_pkg::way_mask_t               way_dirty;
	dcache_line_pkg::way_mask_t               way_wr;
	dcache_line_pkg::way_mask_t               way_fill;
	dcache_line_pkg::line_t [`DC_WAYS-1:0]    way_data;
	dcache_addr_pkg::ptag_t [`DC_WAYS-1:0]    way_ptag;
	dcache_line_pkg::way_t                    hit_way;
	dcache_line_pkg::way_t                    victim_way;
	logic                                     hit_any;

	// Address split, the tag is everything above index and offset
	assign index       = vadr_i[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
	assign vtag        = vadr_i[`DC_VADR_BITS-1:TAG_LSB];
	assign snoop_index = snoop_padr_i[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
	assign snoop_ptag  = snoop_padr_i[`DC_PADR_BITS-1:TAG_LSB]; 

	// Snoops raised by our own channel never invalidate anything
	assign snoop_en = snoop_v_i && (snoop_cid_i != chan_id_i);

	// ======================================================================
	// Hit selection and steering
	// ======================================================================

	// Highest-numbered hitting way wins if a set ever holds duplicates
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (way_hit[w])
				hit_way = dcache_line_pkg::way_t'(w);
		end
	end

	assign hit_any = enable_i && (|way_hit);

	// Writes go only to the hit way, fills only to the victim way
	always_comb begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			way_wr[w]   = req_i && we_i && hit_any && (hit_way == dcache_line_pkg::way_t'(w));
			way_fill[w] = fill_i && (victim_way == dcache_line_pkg::way_t'(w));
		end
	end

	for (genvar g = 0; g < `DC_WAYS; g++) begin : g_way
		dcache_way_store u_way (
			.clk           (clk),
			.rst           (rst),
			.index_i       (index),
			.vtag_i        (vtag),
			.asid_i        (asid_i),
			.snoop_index_i (snoop_index),
			.snoop_ptag_i  (snoop_ptag),
			.snoop_en_i    (snoop_en),
			.fill_i        (way_fill[g]),
			.fill_ptag_i   (fill_ptag_i),
			.fill_data_i   (fill_data_i),
			.wr_i          (way_wr[g]),
			.wdata_i       (wdata_i),
			.bsel_i        (bsel_i),
			.inv_all_i     (inv_all_i),
			.inv_line_i    (inv_line_i),
			.inv_index_i   (inv_index_i),
			.hit_o         (way_hit[g]),
			.valid_o       (way_valid[g]),
			.dirty_o       (way_dirty[g]),
			.data_o        (way_data[g]),
			.ptag_o        (way_ptag[g])
		);
	end

	dcache_victim u_victim (
		.clk          (clk),
		.rst          (rst),
		.fill_i       (fill_i),
		.valid_i      (way_valid),
		.dirty_i      (way_dirty),
		.ptag_i       (way_ptag),
		.data_i       (way_data),
		.index_i      (index),
		.victim_way_o (victim_way),
		.dump_o       (dump_o),
		.dump_padr_o  (dump_padr_o),
		.dump_data_o  (dump_data_o)
	);

	// ======================================================================
	// Registered response
	// ======================================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			resp_valid_o <= 1'b0;
			hit_o        <= 1'b0;
		end else begin
			resp_valid_o <= req_i;
			hit_o        <= req_i && hit_any;
		end
	end

	// Read data is captured before any write at the same edge lands
	always_ff @(posedge clk) begin
		if (req_i)
			rdata_o <= way_data[hit_way];
	end

endmodule

//--- verilog/dcache_top.sv
// Top level of the data cache, register block beside the cache core
// Configuration commands reach the store two clocks after the write
// All inputs are single-cycle strobes with no back-pressure
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        cfg_we_i,
	input  logic                        cfg_addr_i,
	input  logic [`DC_CFG_BITS-1:0]     cfg_wdata_i,
	input  logic                        req_i,
	input  logic                        we_i,
	input  dcache_addr_pkg::vadr_t      vadr_i,
	input  dcache_addr_pkg::asid_t      asid_i,
	input  dcache_line_pkg::line_t      wdata_i,
	input  dcache_line_pkg::bsel_t      bsel_i,
	input  logic                        fill_i,
	input  dcache_addr_pkg::ptag_t      fill_ptag_i,
	input  dcache_line_pkg::line_t      fill_data_i,
	input  logic                        snoop_v_i,
	input  dcache_addr_pkg::padr_t      snoop_padr_i,
	input  dcache_addr_pkg::chan_id_t   snoop_cid_i,
	output logic                        resp_valid_o,
	output logic                        hit_o,
	output dcache_line_pkg::line_t      rdata_o,
	output logic                        dump_o,
	output dcache_addr_pkg::padr_t      dump_padr_o,
	output dcache_line_pkg::line_t      dump_data_o
);

	logic                        enable;
	dcache_addr_pkg::chan_id_t   chan_id;
	logic                        inv_all;
	logic                        inv_line;
	dcache_addr_pkg::index_t     inv_index;

	dcache_ctrl_regs u_regs (
		.clk         (clk),
		.rst         (rst),
		.cfg_we_i    (cfg_we_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.enable_o    (enable),
		.chan_id_o   (chan_id),
		.inv_all_o   (inv_all),
		.inv_line_o  (inv_line),
		.inv_index_o (inv_index)
	);

	dcache_core u_core (
		.clk          (clk),
		.rst          (rst),
		.enable_i     (enable),
		.chan_id_i    (chan_id),
		.req_i        (req_i),
		.we_i         (we_i),
		.vadr_i       (vadr_i),
		.asid_i       (asid_i),
		.wdata_i      (wdata_i),
		.bsel_i       (bsel_i),
		.fill_i       (fill_i),
		.fill_ptag_i  (fill_ptag_i),
		.fill_data_i  (fill_data_i),
		.snoop_v_i    (snoop_v_i),
		.snoop_padr_i (snoop_padr_i),
		.snoop_cid_i  (snoop_cid_i),
		.inv_all_i    (inv_all),
		.inv_line_i   (inv_line),
		.inv_index_i  (inv_index),
		.resp_valid_o (resp_valid_o),
		.hit_o        (hit_o),
		.rdata_o      (rdata_o),
		.dump_o       (dump_o),
		.dump_padr_o  (dump_padr_o),
		.dump_data_o  (dump_data_o)
	);

endmodule

//--- dv/dcache_tb.sv
// Directed testbench for the data cache top level with a shadow model
// Inputs change 2 ns after the rising edge, results are read right after
// The model does not know the way layout, only which lines are resident
// A clean eviction is unknown to the model until the set is probed again
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tb;

	localparam int PERIOD = 40;
	// Reset and the directed sequence take just under 60 cycles
	localparam int PLAN_CYCLES = 60;
	localparam int LIMIT_NS = PLAN_CYCLES * PERIOD * 12 / 10;
	localparam int TAG_LSB = `DC_OFFSET_BITS + `DC_INDEX_BITS;

	logic                       clk;
	logic                       rst;
	logic                       cfg_we_i;
	logic                       cfg_addr_i;
	logic [`DC_CFG_BITS-1:0]    cfg_wdata_i;
	logic                       req_i;
	logic                       we_i;
	dcache_addr_pkg::vadr_t     vadr_i;
	dcache_addr_pkg::asid_t     asid_i;
	dcache_line_pkg::line_t     wdata_i;
	dcache_line_pkg::bsel_t     bsel_i;
	logic                       fill_i;
	dcache_addr_pkg::ptag_t     fill_ptag_i;
	dcache_line_pkg::line_t     fill_data_i;
	logic                       snoop_v_i;
	dcache_addr_pkg::padr_t     snoop_padr_i;
	dcache_addr_pkg::chan_id_t  snoop_cid_i;
	logic                       resp_valid_o;
	logic                       hit_o;
	dcache_line_pkg::line_t     rdata_o;
	logic                       dump_o;
	dcache_addr_pkg::padr_t     dump_padr_o;
	dcache_line_pkg::line_t     dump_data_o;

	// The shadow model keeps one slot per resident line of a set in no particular order
	logic                       m_valid [`DC_LINES][`DC_WAYS];
	logic                       m_dirty [`DC_LINES][`DC_WAYS];
	dcache_addr_pkg::vadr_t     m_vadr  [`DC_LINES][`DC_WAYS];
	dcache_addr_pkg::asid_t     m_asid  [`DC_LINES][`DC_WAYS];
	dcache_addr_pkg::ptag_t     m_ptag  [`DC_LINES][`DC_WAYS];
	dcache_line_pkg::line_t     m_data  [`DC_LINES][`DC_WAYS];
	logic                       m_enable;
	dcache_addr_pkg::chan_id_t  m_cid;
	dcache_addr_pkg::vadr_t     saved_va [$];
	dcache_addr_pkg::asid_t     saved_as [$];

	dcache_top uut (.*);

	always #(PERIOD / 2) clk = ~clk;

	task automatic stop_on_error(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// ======================================================================
	// Protocol timing is sampled at the falling edge where nothing moves
	// ======================================================================
	assert property (@(negedge clk) disable iff (rst) resp_valid_o == $past(req_i))
		else stop_on_error("resp_valid_o did not follow req_i by one cycle");
	assert property (@(negedge clk) disable iff (rst) dump_o |-> $past(fill_i))
		else stop_on_error("dump_o pulsed without a fill one cycle before");

	initial begin
		#(LIMIT_NS);
		$display("Timeout: the tests did not finish within %0d ns", LIMIT_NS);
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	// ======================================================================
	// Stimulus helpers and model upkeep
	// ======================================================================
	function automatic dcache_addr_pkg::vadr_t make_vadr(input dcache_addr_pkg::index_t idx);
		logic [31:0] r;
		r = $urandom();
		return {r[31:TAG_LSB], idx, {`DC_OFFSET_BITS{1'b0}}};
	endfunction

	function automatic dcache_addr_pkg::ptag_t make_ptag();
		logic [31:0] r;
		r = $urandom();
		return r[`DC_PADR_BITS-TAG_LSB-1:0];
	endfunction

	function automatic dcache_line_pkg::line_t make_line();
		return {$urandom(), $urandom()};
	endfunction

	// Slot of a resident line with this tag and asid, or -1
	function automatic int find_line(input dcache_addr_pkg::vadr_t va,
			input dcache_addr_pkg::asid_t as);
		dcache_addr_pkg::index_t idx;
		idx = va[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (m_valid[idx][w] && m_asid[idx][w] == as &&
					m_vadr[idx][w][`DC_VADR_BITS-1:TAG_LSB] == va[`DC_VADR_BITS-1:TAG_LSB])
				return w;
		end
		return -1;
	endfunction

	function automatic int free_slot(input dcache_addr_pkg::index_t idx);
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (!m_valid[idx][w])
				return w;
		end
		return -1;
	endfunction

	function automatic void model_insert(input dcache_addr_pkg::vadr_t va,
			input dcache_addr_pkg::asid_t as, input dcache_addr_pkg::ptag_t pt,
			input dcache_line_pkg::line_t d);
		dcache_addr_pkg::index_t idx;
		int s;
		idx = va[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
		s = free_slot(idx);
		m_valid[idx][s] = 1'b1;
		m_dirty[idx][s] = 1'b0;
		m_vadr[idx][s]  = va;
		m_asid[idx][s]  = as;
		m_ptag[idx][s]  = pt;
		m_data[idx][s]  = d;
	endfunction

	// One read request that returns what came back one cycle later
	task automatic lookup(input dcache_addr_pkg::vadr_t va, input dcache_addr_pkg::asid_t as,
			output logic hit, output dcache_line_pkg::line_t data);
		req_i  = 1'b1;
		we_i   = 1'b0;
		vadr_i = va;
		asid_i = as;
		@(posedge clk);
		#2;
		req_i = 1'b0;
		assert (resp_valid_o) else stop_on_error("no response one cycle after a lookup");
		hit  = hit_o;
		data = rdata_o;
	endtask

	task automatic check_lookup(input dcache_addr_pkg::vadr_t va,
			input dcache_addr_pkg::asid_t as);
		dcache_addr_pkg::index_t idx;
		int s;
		logic hit;
		dcache_line_pkg::line_t data;
		idx = va[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
		s = find_line(va, as);
		lookup(va, as, hit, data);
		assert (hit == (m_enable && s >= 0))
			else stop_on_error($sformatf("hit %0b for vadr %h asid %h", hit, va, as));
		if (hit) begin
			assert (data == m_data[idx][s])
				else stop_on_error($sformatf("read %h, expected %h", data, m_data[idx][s]));
		end
	endtask

	// A write request that hits merges the selected bytes and marks the line modified
	task automatic write_line(input dcache_addr_pkg::vadr_t va, input dcache_addr_pkg::asid_t as,
			input dcache_line_pkg::line_t wd, input dcache_line_pkg::bsel_t bs);
		dcache_addr_pkg::index_t idx;
		int s;
		logic exp_hit;
		idx = va[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
		s = find_line(va, as);
		exp_hit = m_enable && s >= 0;
		req_i   = 1'b1;
		we_i    = 1'b1;
		vadr_i  = va;
		asid_i  = as;
		wdata_i = wd;
		bsel_i  = bs;
		@(posedge clk);
		#2;
		req_i = 1'b0;
		we_i  = 1'b0;
		assert (resp_valid_o && hit_o == exp_hit)
			else stop_on_error($sformatf("write hit %0b, expected %0b", hit_o, exp_hit));
		if (exp_hit) begin
			for (int b = 0; b < `DC_LINE_BITS / 8; b++) begin
				if (bs[b])
					m_data[idx][s][b*8 +: 8] = wd[b*8 +: 8];
			end
			m_dirty[idx][s] = 1'b1;
		end
	endtask

	// The dump that follows a line fill is matched against the modified lines
	task automatic fill_line(input dcache_addr_pkg::vadr_t va, input dcache_addr_pkg::asid_t as,
			input dcache_addr_pkg::ptag_t pt, input dcache_line_pkg::line_t d);
		dcache_addr_pkg::index_t idx;
		int s;
		int victim;
		logic any_clean;
		idx = va[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
		s = free_slot(idx);
		victim = -1;
		any_clean = 1'b0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (!m_dirty[idx][w])
				any_clean = 1'b1;
		end
		fill_i      = 1'b1;
		vadr_i      = va;
		asid_i      = as;
		fill_ptag_i = pt;
		fill_data_i = d;
		@(posedge clk);
		#2;
		fill_i = 1'b0;
		if (s >= 0) begin
			assert (!dump_o) else stop_on_error("dump on a fill into a free way");
		end else if (dump_o) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				if (m_ptag[idx][w] == dump_padr_o[`DC_PADR_BITS-1:TAG_LSB])
					victim = w;
			end
			assert (victim >= 0 && dump_padr_o[TAG_LSB-1:0] == {idx, {`DC_OFFSET_BITS{1'b0}}})
				else stop_on_error($sformatf("dump address %h is no resident line", dump_padr_o));
			assert (m_dirty[idx][victim] && dump_data_o == m_data[idx][victim])
				else stop_on_error($sformatf("dump data %h, expected %h",
					dump_data_o, m_data[idx][victim]));
			m_valid[idx][victim] = 1'b0;
		end else begin
			assert (any_clean) else stop_on_error("a modified line was evicted without a dump");
			// Which clean line went is unknown, so all of them leave the model
			for (int w = 0; w < `DC_WAYS; w++) begin
				if (!m_dirty[idx][w])
					m_valid[idx][w] = 1'b0;
			end
		end
		model_insert(va, as, pt, d);
	endtask

	task automatic snoop(input dcache_addr_pkg::padr_t padr,
			input dcache_addr_pkg::chan_id_t cid);
		dcache_addr_pkg::index_t idx;
		idx = padr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
		snoop_v_i    = 1'b1;
		snoop_padr_i = padr;
		snoop_cid_i  = cid;
		@(posedge clk);
		#2;
		snoop_v_i = 1'b0;
		if (cid != m_cid) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				if (m_ptag[idx][w] == padr[`DC_PADR_BITS-1:TAG_LSB])
					m_valid[idx][w] = 1'b0;
			end
		end
	endtask

	task automatic cfg_write(input logic addr, input logic [`DC_CFG_BITS-1:0] data);
		cfg_we_i    = 1'b1;
		cfg_addr_i  = addr;
		cfg_wdata_i = data;
		@(posedge clk);
		#2;
		cfg_we_i = 1'b0;
		if (!addr) begin
			m_enable = data[0];
			m_cid    = data[7:4];
		end else begin
			// The command strobe is registered and the store clears one clock later
			@(posedge clk);
			#2;
			for (int s = 0; s < `DC_LINES; s++) begin
				for (int w = 0; w < `DC_WAYS; w++) begin
					if (data[0] || (data[1] && dcache_addr_pkg::index_t'(s) == data[11:8]))
						m_valid[s][w] = 1'b0;
				end
			end
		end
	endtask

	// Remember resident lines of one set, or of all sets when only is negative
	task automatic save_lines(input int only);
		saved_va.delete();
		saved_as.delete();
		for (int s = 0; s < `DC_LINES; s++) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				if (m_valid[s][w] && (only < 0 || s == only)) begin
					saved_va.push_back(m_vadr[s][w]);
					saved_as.push_back(m_asid[s][w]);
				end
			end
		end
	endtask

	task automatic check_saved();
		foreach (saved_va[i])
			check_lookup(saved_va[i], saved_as[i]);
	endtask

	task automatic check_resident();
		for (int s = 0; s < `DC_LINES; s++) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				if (m_valid[s][w])
					check_lookup(m_vadr[s][w], m_asid[s][w]);
			end
		end
	endtask

	// ======================================================================
	// Directed sequence
	// ======================================================================
	initial begin
		dcache_addr_pkg::vadr_t  a_va;
		dcache_addr_pkg::vadr_t  b_va;
		dcache_addr_pkg::ptag_t  a_pt;
		dcache_line_pkg::line_t  a_data;
		dcache_addr_pkg::vadr_t  s_va [5];
		dcache_addr_pkg::ptag_t  s_pt [5];
		dcache_addr_pkg::vadr_t  t_va [5];
		dcache_addr_pkg::ptag_t  t_pt [5];
		dcache_line_pkg::line_t  t_data [5];
		logic                    hit;
		dcache_line_pkg::line_t  rd;
		int                      hits;

		void'($urandom(32'h4994_743b));
		clk          = 1'b0;
		rst          = 1'b1;
		cfg_we_i     = 1'b0;
		cfg_addr_i   = 1'b0;
		cfg_wdata_i  = '0;
		req_i        = 1'b0;
		we_i         = 1'b0;
		vadr_i       = '0;
		asid_i       = '0;
		wdata_i      = '0;
		bsel_i       = '0;
		fill_i       = 1'b0;
		fill_ptag_i  = '0;
		fill_data_i  = '0;
		snoop_v_i    = 1'b0;
		snoop_padr_i = '0;
		snoop_cid_i  = '0;
		m_enable     = 1'b0;
		m_cid        = '0;
		for (int s = 0; s < `DC_LINES; s++) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
			end
		end
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		// Enable with own channel id 5, then miss, fill, hit and foreign asid
		cfg_write(1'b0, 16'h0051);
		a_va   = make_vadr(4'h2);
		a_pt   = make_ptag();
		a_data = make_line();
		check_lookup(a_va, 8'h11);
		fill_line(a_va, 8'h11, a_pt, a_data);
		check_lookup(a_va, 8'h11);
		check_lookup(a_va, 8'h22);

		// Byte-masked write hit, then a write miss that must not allocate
		write_line(a_va, 8'h11, make_line(), 8'h5a);
		check_lookup(a_va, 8'h11);
		b_va = make_vadr(4'h2);
		write_line(b_va, 8'h11, make_line(), 8'hff);
		check_lookup(b_va, 8'h11);

		// Four modified lines in set 7, a fifth fill has to dump one of them
		for (int i = 0; i < 5; i++) begin
			s_va[i] = make_vadr(4'h7);
			s_pt[i] = make_ptag();
		end
		for (int i = 0; i < 4; i++)
			fill_line(s_va[i], 8'h11, s_pt[i], make_line());
		for (int i = 0; i < 4; i++)
			write_line(s_va[i], 8'h11, make_line(), 8'hf0);
		fill_line(s_va[4], 8'h11, s_pt[4], make_line());
		for (int i = 0; i < 5; i++)
			check_lookup(s_va[i], 8'h11);

		// Four clean lines in set 9, the fifth fill evicts one without a dump
		for (int i = 0; i < 5; i++) begin
			t_va[i]   = make_vadr(4'h9);
			t_pt[i]   = make_ptag();
			t_data[i] = make_line();
			fill_line(t_va[i], 8'h33, t_pt[i], t_data[i]);
		end
		hits = 0;
		for (int i = 0; i < 4; i++) begin
			lookup(t_va[i], 8'h33, hit, rd);
			assert (!hit || rd == t_data[i])
				else stop_on_error($sformatf("read %h, expected %h", rd, t_data[i]));
			if (hit) begin
				hits++;
				model_insert(t_va[i], 8'h33, t_pt[i], t_data[i]);
			end
		end
		assert (hits == 3)
			else stop_on_error($sformatf("%0d of 4 clean lines left, expected 3", hits));
		check_lookup(t_va[4], 8'h33);

		// Foreign snoop removes a line, a snoop from channel 5 is ignored
		snoop({a_pt, 4'h2, {`DC_OFFSET_BITS{1'b0}}}, 4'h3);
		check_lookup(a_va, 8'h11);
		snoop({s_pt[4], 4'h7, {`DC_OFFSET_BITS{1'b0}}}, 4'h5);
		check_lookup(s_va[4], 8'h11);

		// Invalidate set 7 only, then everything
		save_lines(7);
		cfg_write(1'b1, 16'h0702);
		check_saved();
		check_resident();
		save_lines(-1);
		cfg_write(1'b1, 16'h0001);
		check_saved();

		// With the enable bit cleared even a fresh line misses
		fill_line(a_va, 8'h11, a_pt, a_data);
		check_lookup(a_va, 8'h11);
		cfg_write(1'b0, 16'h0050);
		check_lookup(a_va, 8'h11);

		$display("All checks passed");
		$finish;
	end

endmodule

//--- project.f
+incdir+verilog
verilog/dcache_addr_pkg.sv
verilog/dcache_line_pkg.sv
verilog/dcache_ctrl_regs.sv
verilog/dcache_way_store.sv
verilog/dcache_victim.sv
verilog/dcache_core.sv
verilog/dcache_top.sv
dv/dcache_tb.sv

//--- run.sh
#!/bin/sh
# Build the data cache testbench with Verilator and run it
# The exit status of the simulation is the result of the run
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
	--top-module dcache_tb -o dcache_sim

./obj_dir/dcache_sim
